/* logic/egress_macros.svh */
// Egress stage sizing
`ifndef EGRESS_MACROS_SVH
`define EGRESS_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Core side

// Bytes in one word from the switching core
`define EGR_WORD_BYTES 8

////////////////////////////////////////////////////////////////////////////
// Port side

`define EGR_NUM_PORTS 4
// 8-bit ports take the lowest port numbers, the rest are 32-bit
`define EGR_NUM_8B_PORTS 2
`define EGR_FIFO_DEPTH 4

`endif

/* logic/egress_pkg.sv */
// Egress shared types
`include "egress_macros.svh"

package egress_pkg;

    // Full word as delivered by the switching core
    typedef logic [`EGR_WORD_BYTES*8-1:0] egr_word_t;

    // Egress port number carried with each core beat
    typedef logic [$clog2(`EGR_NUM_PORTS)-1:0] egr_port_t;

    // One bit per egress port
    typedef logic [`EGR_NUM_PORTS-1:0] egr_port_mask_t;

    typedef enum logic {
        WAIT_FIRST,
        IN_PACKET
    } decode_state_e;

    typedef enum logic {
        EMPTY,
        SENDING
    } narrow_state_e;

endpackage

/* logic/egress_port_decode.sv */
// Egress port decode
`timescale 1ns/1ps

module egress_port_decode (
    input  logic                       clk_ifc,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  egress_pkg::egr_word_t      in_data,
    input  egress_pkg::egr_port_t      in_port,
    input  logic                       in_last,
    output egress_pkg::egr_port_mask_t wr_valid,
    output egress_pkg::egr_word_t      wr_data,
    output logic                       wr_last
);

    egress_pkg::decode_state_e state;
    egress_pkg::egr_port_t     held_port;
    egress_pkg::egr_port_t     cur_port;

    // Tag is only trusted on the first beat of a packet
    assign cur_port = (state == egress_pkg::WAIT_FIRST) ? in_port : held_port;

    ////////////////////////////////////////////////////////////////////////////
    // Packet tracking and write strobe

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            state     <= egress_pkg::WAIT_FIRST;
            held_port <= '0;
            wr_valid  <= '0;
        end else begin
            wr_valid <= '0;
            if (in_valid) begin
                // One-hot strobe into the selected port buffer
                wr_valid  <= egress_pkg::egr_port_mask_t'(1) << cur_port;
                held_port <= cur_port;
                if (in_last) begin
                    state <= egress_pkg::WAIT_FIRST;
                end else begin
                    state <= egress_pkg::IN_PACKET;
                end
            end
        end
    end

    // Word and end flag follow the strobe by the same cycle
    always_ff @(posedge clk_ifc) begin
        if (in_valid) begin
            wr_data <= in_data;
            wr_last <= in_last;
        end
    end

endmodule

/* logic/egress_word_fifo.sv */
// Egress port word buffer
`timescale 1ns/1ps
`include "egress_macros.svh"

module egress_word_fifo (
    input  logic                  clk_ifc,
    input  logic                  rst_n,
    input  logic                  wr_valid,
    input  egress_pkg::egr_word_t wr_data,
    input  logic                  wr_last,
    output logic                  rd_valid,
    output egress_pkg::egr_word_t rd_data,
    output logic                  rd_last,
    input  logic                  rd_ready,
    output logic                  overflow
);

    localparam int DEPTH = `EGR_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    egress_pkg::egr_word_t mem_data [DEPTH];
    logic [DEPTH-1:0]      mem_last;
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic                  full;
    logic                  push;
    logic                  pop;

    // Wrap at the buffer depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == CNT_W'(DEPTH));
    assign push = wr_valid && !full;
    assign pop  = rd_valid && rd_ready;

    assign rd_valid = (count != '0);
    assign rd_data  = mem_data[rd_ptr];
    assign rd_last  = mem_last[rd_ptr];

    ////////////////////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge clk_ifc) begin
        if (push) begin
            mem_data[wr_ptr] <= wr_data;
            mem_last[wr_ptr] <= wr_last;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers, occupancy and overflow

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Word dropped, flag holds until reset
            if (wr_valid && full) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

/* logic/egress_width_narrow.sv */
// Egress width narrowing
`timescale 1ns/1ps
`include "egress_macros.svh"

module egress_width_narrow #(
    parameter int LANE_BYTES = 1
) (
    input  logic                    clk_ifc,
    input  logic                    rst_n,
    input  logic                    rd_valid,
    input  egress_pkg::egr_word_t   rd_data,
    input  logic                    rd_last,
    output logic                    rd_ready,
    output logic                    out_valid,
    output logic [LANE_BYTES*8-1:0] out_data,
    output logic                    out_last,
    input  logic                    out_ready
);

    localparam int LANE_BITS = LANE_BYTES * 8;
    localparam int BEATS     = `EGR_WORD_BYTES / LANE_BYTES;
    localparam int CNT_W     = (BEATS > 1) ? $clog2(BEATS) : 1;

    egress_pkg::narrow_state_e state;
    egress_pkg::egr_word_t     shift_reg;
    logic                      word_last;
    logic [CNT_W-1:0]          beat_cnt;
    logic                      beat_final;

    assign beat_final = (beat_cnt == CNT_W'(BEATS - 1));

    // Only pull a new word once the current one is fully sent
    assign rd_ready = (state == egress_pkg::EMPTY);

    assign out_valid = (state == egress_pkg::SENDING);
    assign out_data  = shift_reg[LANE_BITS-1:0];
    // End of packet only on the top lane of a word flagged last
    assign out_last  = out_valid && word_last && beat_final;

    ////////////////////////////////////////////////////////////////////////////
    // State and beat counter

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            state    <= egress_pkg::EMPTY;
            beat_cnt <= '0;
        end else begin
            case (state)
                egress_pkg::EMPTY: begin
                    if (rd_valid) begin
                        state    <= egress_pkg::SENDING;
                        beat_cnt <= '0;
                    end
                end
                egress_pkg::SENDING: begin
                    if (out_ready) begin
                        if (beat_final) begin
                            state <= egress_pkg::EMPTY;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                default: state <= egress_pkg::EMPTY;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Word holding register, lowest byte leaves first

    always_ff @(posedge clk_ifc) begin
        if (rd_ready && rd_valid) begin
            shift_reg <= rd_data;
            word_last <= rd_last;
        end else if (out_valid && out_ready && !beat_final) begin
            shift_reg <= shift_reg >> LANE_BITS;
        end
    end

endmodule

/* logic/mpls_egress.sv */
// MPLS egress stage top
`timescale 1ns/1ps
`include "egress_macros.svh"

module mpls_egress (
    input  logic                                          clk_ifc,
    input  logic                                          rst_n,
    // Core side, cannot be stalled
    input  logic                                          in_valid,
    input  egress_pkg::egr_word_t                         in_data,
    input  egress_pkg::egr_port_t                         in_port,
    input  logic                                          in_last,
    // 8-bit ports
    output logic [`EGR_NUM_8B_PORTS-1:0]                  out8_valid,
    input  logic [`EGR_NUM_8B_PORTS-1:0]                  out8_ready,
    output logic [`EGR_NUM_8B_PORTS-1:0][7:0]             out8_data,
    output logic [`EGR_NUM_8B_PORTS-1:0]                  out8_last,
    // 32-bit ports
    output logic [`EGR_NUM_PORTS-`EGR_NUM_8B_PORTS-1:0]       out32_valid,
    input  logic [`EGR_NUM_PORTS-`EGR_NUM_8B_PORTS-1:0]       out32_ready,
    output logic [`EGR_NUM_PORTS-`EGR_NUM_8B_PORTS-1:0][31:0] out32_data,
    output logic [`EGR_NUM_PORTS-`EGR_NUM_8B_PORTS-1:0]       out32_last,
    output egress_pkg::egr_port_mask_t                    overflow
);

    localparam int NUM_8B  = `EGR_NUM_8B_PORTS;
    localparam int NUM_32B = `EGR_NUM_PORTS - `EGR_NUM_8B_PORTS;

    egress_pkg::egr_port_mask_t wr_valid;
    egress_pkg::egr_word_t      wr_data;
    logic                       wr_last;

    egress_pkg::egr_port_mask_t rd_valid;
    egress_pkg::egr_word_t      rd_data [`EGR_NUM_PORTS];
    egress_pkg::egr_port_mask_t rd_last;
    egress_pkg::egr_port_mask_t rd_ready;

    ////////////////////////////////////////////////////////////////////////////
    // Input side

    egress_port_decode u_decode (
        .clk_ifc  (clk_ifc),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_port  (in_port),
        .in_last  (in_last),
        .wr_valid (wr_valid),
        .wr_data  (wr_data),
        .wr_last  (wr_last)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Per-port word buffers

    for (genvar p = 0; p < `EGR_NUM_PORTS; p++) begin : g_fifo
        egress_word_fifo u_fifo (
            .clk_ifc  (clk_ifc),
            .rst_n    (rst_n),
            .wr_valid (wr_valid[p]),
            .wr_data  (wr_data),
            .wr_last  (wr_last),
            .rd_valid (rd_valid[p]),
            .rd_data  (rd_data[p]),
            .rd_last  (rd_last[p]),
            .rd_ready (rd_ready[p]),
            .overflow (overflow[p])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output side

    for (genvar i = 0; i < NUM_8B; i++) begin : g_narrow8
        egress_width_narrow #(
            .LANE_BYTES (1)
        ) u_narrow (
            .clk_ifc   (clk_ifc),
            .rst_n     (rst_n),
            .rd_valid  (rd_valid[i]),
            .rd_data   (rd_data[i]),
            .rd_last   (rd_last[i]),
            .rd_ready  (rd_ready[i]),
            .out_valid (out8_valid[i]),
            .out_data  (out8_data[i]),
            .out_last  (out8_last[i]),
            .out_ready (out8_ready[i])
        );
    end

    // 32-bit ports follow the 8-bit ones in port numbering
    for (genvar i = 0; i < NUM_32B; i++) begin : g_narrow32
        egress_width_narrow #(
            .LANE_BYTES (4)
        ) u_narrow (
            .clk_ifc   (clk_ifc),
            .rst_n     (rst_n),
            .rd_valid  (rd_valid[NUM_8B + i]),
            .rd_data   (rd_data[NUM_8B + i]),
            .rd_last   (rd_last[NUM_8B + i]),
            .rd_ready  (rd_ready[NUM_8B + i]),
            .out_valid (out32_valid[i]),
            .out_data  (out32_data[i]),
            .out_last  (out32_last[i]),
            .out_ready (out32_ready[i])
        );
    end

endmodule

/* dv/mpls_egress_properties.sv */
// Egress handshake and flag checks
`timescale 1ns/1ps

module mpls_egress_properties #(
    parameter int DATA_W = 8
) (
    input logic              clk_ifc,
    input logic              rst_n,
    input logic              valid,
    input logic              ready,
    input logic [DATA_W-1:0] data,
    input logic              last,
    input logic              sticky,
    input logic              pull,
    input logic              offer
);

    // A stalled beat keeps its data and end flag
    stall_hold: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        valid && !ready |=> valid && $stable(data) && $stable(last))
        else $error("output beat changed while stalled");

    sticky_hold: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        sticky |=> sticky)
        else $error("overflow flag cleared without reset");

    reset_quiet: assert property (@(posedge clk_ifc)
        !rst_n |=> !valid)
        else $error("output valid high after reset");

    // A word taken from the buffer starts its beats and closes the pull
    pull_empty: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        pull && offer |=> valid && !pull)
        else $error("word requested while still sending");

endmodule

bind egress_width_narrow mpls_egress_properties #(
    .DATA_W (LANE_BYTES * 8)
) u_narrow_props (
    .clk_ifc (clk_ifc),
    .rst_n   (rst_n),
    .valid   (out_valid),
    .ready   (out_ready),
    .data    (out_data),
    .last    (out_last),
    .sticky  (1'b0),
    .pull    (rd_ready),
    .offer   (rd_valid)
);

bind egress_word_fifo mpls_egress_properties #(
    .DATA_W (1)
) u_fifo_props (
    .clk_ifc (clk_ifc),
    .rst_n   (rst_n),
    .valid   (1'b0),
    .ready   (1'b1),
    .data    (1'b0),
    .last    (1'b0),
    .sticky  (overflow),
    .pull    (1'b0),
    .offer   (1'b0)
);

/* dv/mpls_egress_tb.sv */
// MPLS egress stage testbench
`timescale 1ns/1ps
`include "egress_macros.svh"

module mpls_egress_tb;

    localparam int SEED       = 82656;
    localparam int NUM_PKTS   = 60;
    localparam int SPACE_FAST = 9;
    localparam int SPACE_SLOW = 20;
    localparam int SPACE_OVF  = 3;
    // Average packet is 3.5 words, so the limit is about twice the sum of all tests
    localparam int TIMEOUT_CYCLES = NUM_PKTS * 7 * (3 * SPACE_FAST + SPACE_SLOW);

    logic                       clk_ifc;
    logic                       rst_n;
    logic                       in_valid;
    egress_pkg::egr_word_t      in_data;
    egress_pkg::egr_port_t      in_port;
    logic                       in_last;
    logic [1:0]                 out8_valid;
    logic [1:0]                 out8_ready;
    logic [1:0][7:0]            out8_data;
    logic [1:0]                 out8_last;
    logic [1:0]                 out32_valid;
    logic [1:0]                 out32_ready;
    logic [1:0][31:0]           out32_data;
    logic [1:0]                 out32_last;
    egress_pkg::egr_port_mask_t overflow;

    int   seed;
    int   cycle_count = 0;
    int   error_count = 0;
    int   err_start;
    int   tests_passed = 0;
    int   tests_failed = 0;
    int   lasts_seen;
    logic rand_ready;
    logic stall_port2;

    // Reference model, one byte stream per port with its end-of-packet marks
    logic [7:0] exp_byte [`EGR_NUM_PORTS][$];
    logic       exp_end  [`EGR_NUM_PORTS][$];

    mpls_egress UUT (.*);

    initial begin
        clk_ifc = 1'b0;
        forever #20 clk_ifc = ~clk_ifc;
    end

    always @(posedge clk_ifc) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers

    // Advance one clock and drive the output readies for it
    task automatic next_cycle();
        logic [3:0] mask;
        @(posedge clk_ifc);
        mask = '1;
        if (rand_ready) begin
            for (int b = 0; b < 4; b++) begin
                mask[b] = (($random(seed) & 3) != 0);
            end
        end
        if (stall_port2) begin
            mask[2] = 1'b0;
        end
        out8_ready  <= mask[1:0];
        out32_ready <= mask[3:2];
    endtask

    task automatic apply_reset();
        for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
            exp_byte[p].delete();
            exp_end[p].delete();
        end
        rst_n <= 1'b0;
        repeat (4) next_cycle();
        rst_n <= 1'b1;
    endtask

    task automatic push_model(input int port, input egress_pkg::egr_word_t word,
                              input logic last);
        for (int b = 0; b < `EGR_WORD_BYTES; b++) begin
            exp_byte[port].push_back(word[b*8 +: 8]);
            exp_end[port].push_back(last && (b == `EGR_WORD_BYTES - 1));
        end
    endtask

    // One core beat, then idle until the next beat slot
    task automatic drive_word(input egress_pkg::egr_word_t word, input logic [1:0] tag,
                              input logic last, input int gap);
        next_cycle();
        in_valid <= 1'b1;
        in_data  <= word;
        in_port  <= tag;
        in_last  <= last;
        next_cycle();
        in_valid <= 1'b0;
        repeat (gap - 2) next_cycle();
    endtask

    task automatic send_random_packets(input int gap, input logic scramble);
        egress_pkg::egr_word_t word;
        logic [1:0]            tag;
        int                    port;
        int                    nwords;
        for (int k = 0; k < NUM_PKTS; k++) begin
            port   = $random(seed) & 3;
            nwords = 1 + ($unsigned($random(seed)) % 6);
            for (int w = 0; w < nwords; w++) begin
                word = {$random(seed), $random(seed)};
                tag  = port[1:0];
                // Later beats carry junk tags that the DUT must ignore
                if (scramble && w != 0) begin
                    tag = 2'($random(seed));
                end
                push_model(port, word, w == nwords - 1);
                drive_word(word, tag, w == nwords - 1, gap);
            end
        end
    endtask

    function automatic int pending_bytes();
        int total;
        total = 0;
        for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
            total += exp_byte[p].size();
        end
        return total;
    endfunction

    // Wait for the model to empty, then a quiet spell for stray beats
    task automatic drain();
        while (pending_bytes() != 0) begin
            next_cycle();
        end
        repeat (16) next_cycle();
    endtask

    task automatic check_overflow(input logic [3:0] want);
        if (overflow !== want) begin
            $display("ERR %0t: overflow %b, expected %b", $time, overflow, want);
            error_count++;
        end
    endtask

    task automatic finish_test(input int num, input string name);
        if (error_count == err_start) begin
            $display("Test %0d %s: ok", num, name);
            tests_passed++;
        end else begin
            $display("Test %0d %s: %0d errors", num, name, error_count - err_start);
            tests_failed++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Output monitor

    task automatic check_beat(input int port, input int nbytes, input logic [31:0] data,
                              input logic last);
        logic [7:0] want;
        logic       want_last;
        want_last = 1'b0;
        for (int b = 0; b < nbytes; b++) begin
            if (exp_byte[port].size() == 0) begin
                $display("ERR %0t: unexpected beat on port %0d", $time, port);
                error_count++;
                return;
            end
            want      = exp_byte[port].pop_front();
            want_last = exp_end[port].pop_front();
            if (data[b*8 +: 8] !== want) begin
                $display("ERR %0t: port %0d lane %0d got %h, expected %h",
                         $time, port, b, data[b*8 +: 8], want);
                error_count++;
            end
        end
        if (last !== want_last) begin
            $display("ERR %0t: port %0d last %b, expected %b", $time, port, last, want_last);
            error_count++;
        end
        if (last) begin
            lasts_seen++;
        end
    endtask

    // Sampled mid-cycle, where outputs and readies are settled
    always @(negedge clk_ifc) begin
        if (rst_n) begin
            for (int p = 0; p < 2; p++) begin
                if (out8_valid[p] && out8_ready[p]) begin
                    check_beat(p, 1, {24'h0, out8_data[p]}, out8_last[p]);
                end
                if (out32_valid[p] && out32_ready[p]) begin
                    check_beat(p + 2, 4, out32_data[p], out32_last[p]);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    task automatic run_overflow_test();
        egress_pkg::egr_word_t word;
        stall_port2 = 1'b1;
        // The narrower holds one word and the buffer the rest
        for (int k = 0; k <= `EGR_FIFO_DEPTH + 1; k++) begin
            word = {$random(seed), $random(seed)};
            if (k <= `EGR_FIFO_DEPTH) begin
                push_model(2, word, 1'b1);
            end
            drive_word(word, 2'd2, 1'b1, SPACE_OVF);
            @(negedge clk_ifc);
            check_overflow((k <= `EGR_FIFO_DEPTH) ? 4'b0000 : 4'b0100);
        end
        stall_port2 = 1'b0;
        drain();
        @(negedge clk_ifc);
        check_overflow(4'b0100);
        next_cycle();
        apply_reset();
        next_cycle();
        @(negedge clk_ifc);
        check_overflow(4'b0000);
    endtask

    initial begin
        seed        = SEED;
        rand_ready  = 1'b0;
        stall_port2 = 1'b0;
        rst_n       <= 1'b0;
        in_valid    <= 1'b0;
        in_data     <= '0;
        in_port     <= '0;
        in_last     <= 1'b0;
        out8_ready  <= '1;
        out32_ready <= '1;

        err_start = error_count;
        apply_reset();
        send_random_packets(SPACE_FAST, 1'b0);
        drain();
        @(negedge clk_ifc);
        check_overflow(4'b0000);
        finish_test(1, "routing");

        err_start  = error_count;
        apply_reset();
        lasts_seen = 0;
        send_random_packets(SPACE_FAST, 1'b0);
        drain();
        if (lasts_seen != NUM_PKTS) begin
            $display("ERR %0t: %0d packet ends seen, expected %0d", $time, lasts_seen, NUM_PKTS);
            error_count++;
        end
        finish_test(2, "packet end");

        err_start = error_count;
        apply_reset();
        send_random_packets(SPACE_FAST, 1'b1);
        drain();
        @(negedge clk_ifc);
        check_overflow(4'b0000);
        finish_test(3, "tag hold");

        err_start  = error_count;
        apply_reset();
        rand_ready = 1'b1;
        send_random_packets(SPACE_SLOW, 1'b0);
        drain();
        rand_ready = 1'b0;
        @(negedge clk_ifc);
        check_overflow(4'b0000);
        finish_test(4, "back-pressure");

        err_start = error_count;
        next_cycle();
        apply_reset();
        run_overflow_test();
        finish_test(5, "overflow");

        $display("Tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+logic
logic/egress_pkg.sv
logic/egress_port_decode.sv
logic/egress_word_fifo.sv
logic/egress_width_narrow.sv
logic/mpls_egress.sv
dv/mpls_egress_properties.sv
dv/mpls_egress_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the MPLS egress testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f all.f \
    --top-module mpls_egress_tb \
    -o mpls_egress_sim

# The run counts as passed only if the testbench printed its pass line
./obj_dir/mpls_egress_sim | tee /dev/stderr | grep -x "TB PASSED" > /dev/null
echo "Simulation passed"
